//--- project.f
src/ps2_pkg.sv
src/key_display_if.sv
src/ps2_line_filter.sv
src/ps2_frame_receiver.sv
src/scan_code_tracker.sv
src/segment_display.sv
src/ps2_keyboard_display.sv
testbench/tb_ps2_keyboard_display.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PS/2 keyboard display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ps2_keyboard_display \
    --Mdir build \
    -f project.f

sim_status=0
./build/Vtb_ps2_keyboard_display > sim.log 2>&1 || sim_status=$?
cat sim.log

if [ "$sim_status" -eq 0 ] && grep -qx "Verification passed" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi

//--- src/key_display_if.sv
`timescale 1ns/100ps

interface key_display_if;
    import ps2_pkg::*;

    // the fields below mean something only in the cycle where update is high
    logic       update;
    scan_byte_u prefix;
    logic       prefix_shown;
    scan_byte_u code;
    logic       code_shown;

    modport tracker (
        output update,
        output prefix,
        output prefix_shown,
        output code,
        output code_shown
    );

    modport display (
        input update,
        input prefix,
        input prefix_shown,
        input code,
        input code_shown
    );

endinterface

//--- src/ps2_frame_receiver.sv
`timescale 1ns/100ps

module ps2_frame_receiver (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    input  logic                fall_pulse,
    input  logic                dat_sync,
    output logic                byte_valid,
    output ps2_pkg::scan_byte_u rx_byte
);
    import ps2_pkg::*;

    logic                   busy;
    logic [BIT_COUNT_W-1:0] bit_cnt;
    logic                   at_stop;
    logic                   shift_en;
    logic                   frame_ok;
    // parity bit sits on top of the data byte once the frame is in
    logic [8:0]             shift_q;

    assign at_stop  = (bit_cnt == BIT_COUNT_W'(FRAME_BITS - 1));
    assign shift_en = fall_pulse & busy & ~at_stop;

    // odd parity over data and parity bit, and the stop bit must be high
    assign frame_ok = (^shift_q) & dat_sync;

    assign rx_byte = scan_byte_u'(shift_q[7:0]);

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (fall_pulse) begin
                if (!busy) begin
                    // only a low data line at an edge counts as a start bit
                    if (!dat_sync) begin
                        busy    <= 1'b1;
                        bit_cnt <= BIT_COUNT_W'(1);
                    end
                end else if (at_stop) begin
                    busy       <= 1'b0;
                    bit_cnt    <= '0;
                    byte_valid <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // data arrives LSB first, so each new bit enters at the top
    always_ff @(posedge CLOCK_50) begin
        if (shift_en) begin
            shift_q <= {dat_sync, shift_q[8:1]};
        end
    end

    a_byte_single : assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        byte_valid |=> !byte_valid);

endmodule

//--- src/ps2_keyboard_display.sv
`timescale 1ns/100ps

module ps2_keyboard_display (
    input  logic       CLOCK_50,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [6:0] hex3,
    output logic [6:0] hex2,
    output logic [6:0] hex1,
    output logic [6:0] hex0
);
    import ps2_pkg::*;

    logic       fall_pulse;
    logic       dat_sync;
    logic       byte_valid;
    scan_byte_u rx_byte;

    key_display_if ev_if ();

    ps2_line_filter u_line_filter (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .fall_pulse (fall_pulse),
        .dat_sync   (dat_sync)
    );

    ps2_frame_receiver u_frame_receiver (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .fall_pulse (fall_pulse),
        .dat_sync   (dat_sync),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    scan_code_tracker u_tracker (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .ev         (ev_if.tracker)
    );

    segment_display u_display (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .ev       (ev_if.display),
        .hex3     (hex3),
        .hex2     (hex2),
        .hex1     (hex1),
        .hex0     (hex0)
    );

endmodule

//--- src/ps2_line_filter.sv
`timescale 1ns/100ps

module ps2_line_filter (
    input  logic CLOCK_50,
    input  logic rst_n,
    input  logic ps2_clk,
    input  logic ps2_dat,
    output logic fall_pulse,
    output logic dat_sync
);
    import ps2_pkg::*;

    logic [SYNC_STAGES-1:0]    clk_pipe;
    logic [SYNC_STAGES-1:0]    dat_pipe;
    logic                      clk_synced;
    logic                      clk_filt;
    logic                      clk_filt_q;
    logic [FILTER_COUNT_W-1:0] stable_cnt;

    assign clk_synced = clk_pipe[SYNC_STAGES-1];
    assign dat_sync   = dat_pipe[SYNC_STAGES-1];

    // both lines idle high, so the chains leave reset high too
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            clk_pipe <= '1;
            dat_pipe <= '1;
        end else begin
            clk_pipe <= {clk_pipe[SYNC_STAGES-2:0], ps2_clk};
            dat_pipe <= {dat_pipe[SYNC_STAGES-2:0], ps2_dat};
        end
    end

    // a differing sample that falls back before the count is up is a glitch
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            clk_filt   <= 1'b1;
            stable_cnt <= '0;
        end else if (clk_synced == clk_filt) begin
            stable_cnt <= '0;
        end else if (stable_cnt == FILTER_COUNT_W'(FILTER_CYCLES - 1)) begin
            clk_filt   <= clk_synced;
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            clk_filt_q <= 1'b1;
            fall_pulse <= 1'b0;
        end else begin
            clk_filt_q <= clk_filt;
            fall_pulse <= clk_filt_q & ~clk_filt;
        end
    end

    a_fall_single : assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        fall_pulse |=> !fall_pulse);

endmodule

//--- src/ps2_pkg.sv
package ps2_pkg;

    // flops in each synchronizer chain
    localparam int SYNC_STAGES = 2;

    // equal samples of the keyboard clock needed before the filtered level follows
    localparam int FILTER_CYCLES  = 8;
    localparam int FILTER_COUNT_W = $clog2(FILTER_CYCLES);

    // start, eight data bits, odd parity, stop
    localparam int FRAME_BITS  = 11;
    localparam int BIT_COUNT_W = $clog2(FRAME_BITS);

    localparam logic [7:0] CODE_EXTENDED = 8'hE0;
    localparam logic [7:0] CODE_BREAK    = 8'hF0;
    localparam logic [7:0] CODE_PAUSE    = 8'hE1;

    // segments are active low, bit 6 is g and bit 0 is a
    localparam logic [6:0] SEG_BLANK = 7'h7F;

    localparam logic [6:0] SEG_GLYPHS [16] = '{
        7'h40,
        7'h79,
        7'h24,
        7'h30,
        7'h19,
        7'h12,
        7'h02,
        7'h78,
        7'h00,
        7'h10,
        7'h08,
        7'h03,
        7'h46,
        7'h21,
        7'h06,
        7'h0E
    };

    // the tracker compares whole bytes, the display picks glyphs per nibble
    typedef union packed {
        logic [7:0] code;
        struct packed {
            logic [3:0] hi;
            logic [3:0] lo;
        } nibble;
    } scan_byte_u;

    typedef enum logic [1:0] {
        seq_idle,
        seq_extended,
        seq_break,
        seq_extended_break
    } seq_state_e;

endpackage

//--- src/scan_code_tracker.sv
`timescale 1ns/100ps

module scan_code_tracker (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    input  logic                byte_valid,
    input  ps2_pkg::scan_byte_u rx_byte,
    key_display_if.tracker      ev
);
    import ps2_pkg::*;

    seq_state_e state;
    seq_state_e nxt_state;
    logic       nxt_update;
    logic       nxt_prefix_shown;
    logic       nxt_code_shown;
    scan_byte_u nxt_prefix;
    logic       seq_error;

    always_comb begin
        nxt_state        = state;
        nxt_update       = 1'b0;
        nxt_prefix_shown = 1'b0;
        nxt_code_shown   = 1'b0;
        nxt_prefix       = scan_byte_u'(CODE_BREAK);
        seq_error        = 1'b0;

        if (byte_valid) begin
            case (rx_byte.code)
                CODE_EXTENDED: begin
                    if (state == seq_idle) begin
                        nxt_state = seq_extended;
                    end else begin
                        seq_error = 1'b1;
                    end
                end
                CODE_BREAK: begin
                    if (state == seq_idle) begin
                        nxt_state = seq_break;
                    end else if (state == seq_extended) begin
                        nxt_state = seq_extended_break;
                    end else begin
                        seq_error = 1'b1;
                    end
                end
                CODE_PAUSE: begin
                    seq_error = 1'b1;
                end
                default: begin
                    // a key code closes the sequence with at most one prefix shown
                    nxt_update       = 1'b1;
                    nxt_code_shown   = 1'b1;
                    nxt_prefix_shown = (state != seq_idle);
                    if (state == seq_extended) begin
                        nxt_prefix = scan_byte_u'(CODE_EXTENDED);
                    end
                    nxt_state = seq_idle;
                end
            endcase

            // an error blanks the display since both shown flags stay low
            if (seq_error) begin
                nxt_update = 1'b1;
                nxt_state  = seq_idle;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= seq_idle;
            ev.update <= 1'b0;
        end else begin
            state     <= nxt_state;
            ev.update <= nxt_update;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (nxt_update) begin
            ev.prefix       <= nxt_prefix;
            ev.prefix_shown <= nxt_prefix_shown;
            ev.code         <= rx_byte;
            ev.code_shown   <= nxt_code_shown;
        end
    end

    a_prefix_needs_code : assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        ev.update |-> (!ev.prefix_shown || ev.code_shown));

endmodule

//--- src/segment_display.sv
`timescale 1ns/100ps

module segment_display (
    input  logic           CLOCK_50,
    input  logic           rst_n,
    key_display_if.display ev,
    output logic [6:0]     hex3,
    output logic [6:0]     hex2,
    output logic [6:0]     hex1,
    output logic [6:0]     hex0
);
    import ps2_pkg::*;

    logic [6:0] prefix_hi_seg;
    logic [6:0] prefix_lo_seg;
    logic [6:0] code_hi_seg;
    logic [6:0] code_lo_seg;

    function automatic logic [6:0] digit_of(input logic shown, input logic [3:0] nib);
        logic [6:0] seg;
        seg = shown ? SEG_GLYPHS[nib] : SEG_BLANK;
        return seg;
    endfunction

    assign prefix_hi_seg = digit_of(ev.prefix_shown, ev.prefix.nibble.hi);
    assign prefix_lo_seg = digit_of(ev.prefix_shown, ev.prefix.nibble.lo);
    assign code_hi_seg   = digit_of(ev.code_shown, ev.code.nibble.hi);
    assign code_lo_seg   = digit_of(ev.code_shown, ev.code.nibble.lo);

    // digits hold their patterns until the next key event or error
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            hex3 <= SEG_BLANK;
            hex2 <= SEG_BLANK;
            hex1 <= SEG_BLANK;
            hex0 <= SEG_BLANK;
        end else if (ev.update) begin
            hex3 <= prefix_hi_seg;
            hex2 <= prefix_lo_seg;
            hex1 <= code_hi_seg;
            hex0 <= code_lo_seg;
        end
    end

endmodule

//--- testbench/tb_ps2_keyboard_display.sv
`timescale 1ns/100ps

module tb_ps2_keyboard_display;

    localparam int HALF_BIT_CYCLES = 40;
    localparam int WAIT_LIMIT      = 400;
    localparam logic [6:0] BLANK   = 7'h7F;

    logic       CLOCK_50;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_dat;
    logic [6:0] hex3;
    logic [6:0] hex2;
    logic [6:0] hex1;
    logic [6:0] hex0;

    logic [6:0] exp_hex3;
    logic [6:0] exp_hex2;
    logic [6:0] exp_hex1;
    logic [6:0] exp_hex0;
    logic       check_en;
    logic [7:0] code;
    int         value_errors;
    int         timeout_errors;

    ps2_keyboard_display dut (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .hex3     (hex3),
        .hex2     (hex2),
        .hex1     (hex1),
        .hex0     (hex0)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #20 CLOCK_50 = ~CLOCK_50;
    end

    // active low segments, written as g f e d c b a
    function automatic logic [6:0] glyph_for(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            4'hF: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

    // prefix bytes are never drawn as key codes
    function automatic logic [7:0] random_code();
        logic [7:0] c;
        c = 8'($urandom);
        while (c == 8'hE0 || c == 8'hF0 || c == 8'hE1) begin
            c = 8'($urandom);
        end
        return c;
    endfunction

    task automatic set_expected(input logic p_shown, input logic [7:0] prefix,
                                input logic c_shown, input logic [7:0] key);
        exp_hex3 = p_shown ? glyph_for(prefix[7:4]) : BLANK;
        exp_hex2 = p_shown ? glyph_for(prefix[3:0]) : BLANK;
        exp_hex1 = c_shown ? glyph_for(key[7:4]) : BLANK;
        exp_hex0 = c_shown ? glyph_for(key[3:0]) : BLANK;
    endtask

    // start, data LSB first, odd parity, stop; data changes while the clock is high
    task automatic send_frame(input logic [7:0] data, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, (~^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_dat = bits[i];
            repeat (HALF_BIT_CYCLES) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            repeat (HALF_BIT_CYCLES) @(negedge CLOCK_50);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        repeat (2 * HALF_BIT_CYCLES) @(negedge CLOCK_50);
    endtask

    task automatic wait_for_digits(input string what);
        int n;
        n = 0;
        while ({hex3, hex2, hex1, hex0} !== {exp_hex3, exp_hex2, exp_hex1, exp_hex0}
               && n < WAIT_LIMIT) begin
            @(negedge CLOCK_50);
            n++;
        end
        if ({hex3, hex2, hex1, hex0} !== {exp_hex3, exp_hex2, exp_hex1, exp_hex0}) begin
            timeout_errors++;
            $display("timeout: the digits never showed the expected pattern after %s", what);
        end
    endtask

    // the byte that ends an event may change the digits, so checking pauses around it
    task automatic send_final(input logic [7:0] data, input logic p_shown,
                              input logic [7:0] prefix, input logic c_shown,
                              input string what);
        check_en = 1'b0;
        send_frame(data, 1'b0, 1'b0);
        set_expected(p_shown, prefix, c_shown, data);
        wait_for_digits(what);
        check_en = 1'b1;
    endtask

    task automatic sequence_error(input logic [7:0] first, input logic [7:0] second,
                                  input string what);
        send_frame(first, 1'b0, 1'b0);
        send_final(second, 1'b0, 8'h00, 1'b0, what);
        send_final(random_code(), 1'b0, 8'h00, 1'b1, "a key code after an error");
    endtask

    a_hex3 : assert property (@(posedge CLOCK_50) disable iff (!check_en) hex3 == exp_hex3)
        else begin
            value_errors++;
            $display("[FAIL] hex3 = %h, expected %h", $sampled(hex3), $sampled(exp_hex3));
        end

    a_hex2 : assert property (@(posedge CLOCK_50) disable iff (!check_en) hex2 == exp_hex2)
        else begin
            value_errors++;
            $display("[FAIL] hex2 = %h, expected %h", $sampled(hex2), $sampled(exp_hex2));
        end

    a_hex1 : assert property (@(posedge CLOCK_50) disable iff (!check_en) hex1 == exp_hex1)
        else begin
            value_errors++;
            $display("[FAIL] hex1 = %h, expected %h", $sampled(hex1), $sampled(exp_hex1));
        end

    a_hex0 : assert property (@(posedge CLOCK_50) disable iff (!check_en) hex0 == exp_hex0)
        else begin
            value_errors++;
            $display("[FAIL] hex0 = %h, expected %h", $sampled(hex0), $sampled(exp_hex0));
        end

    initial begin
        rst_n          = 1'b0;
        ps2_clk        = 1'b1;
        ps2_dat        = 1'b1;
        check_en       = 1'b0;
        code           = 8'h00;
        value_errors   = 0;
        timeout_errors = 0;
        set_expected(1'b0, 8'h00, 1'b0, 8'h00);
        void'($urandom(93607));

        repeat (10) @(negedge CLOCK_50);
        rst_n = 1'b1;
        wait_for_digits("reset");
        check_en = 1'b1;
        repeat (20) @(negedge CLOCK_50);

        for (int k = 0; k < 4; k++) begin
            send_final(random_code(), 1'b0, 8'h00, 1'b1, "a plain key code");
        end

        // prefix bytes alone must leave the digits as they are
        code = random_code();
        send_frame(8'hF0, 1'b0, 1'b0);
        send_final(code, 1'b1, 8'hF0, 1'b1, "a break code");
        code = random_code();
        send_frame(8'hE0, 1'b0, 1'b0);
        send_final(code, 1'b1, 8'hE0, 1'b1, "an extended code");

        code = random_code();
        send_frame(8'hE0, 1'b0, 1'b0);
        send_frame(8'hF0, 1'b0, 1'b0);
        send_final(code, 1'b1, 8'hF0, 1'b1, "an extended break code");

        code = random_code();
        send_frame(code, 1'b1, 1'b0);
        send_frame(code, 1'b0, 1'b1);
        send_final(code, 1'b0, 8'h00, 1'b1, "a good frame after bad frames");

        sequence_error(8'hF0, 8'hF0, "a double break prefix");
        sequence_error(8'hE0, 8'hE0, "a double extended prefix");
        sequence_error(8'hF0, 8'hE0, "an extended prefix after break");
        send_final(8'hE1, 1'b0, 8'h00, 1'b0, "a pause byte");
        code = random_code();
        send_frame(8'hF0, 1'b0, 1'b0);
        send_final(code, 1'b1, 8'hF0, 1'b1, "a break code after an error");

        repeat (10) @(negedge CLOCK_50);
        $display("checks finished with %0d value errors and %0d timeouts",
                 value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
